// File: opl3_slot_config.svh
//********************
// sizes and register window bases for the slot scheduler
// include in any file that needs slot counts or window geometry
//********************
`ifndef OPL3_SLOT_CONFIG_SVH
`define OPL3_SLOT_CONFIG_SVH

`define NUM_BANKS        2
`define OPS_PER_BANK     18
`define NUM_SLOTS        (`NUM_BANKS * `OPS_PER_BANK)
`define SLOT_CYCLES      2        // cycles per operator slot
`define OP_WIN_DEPTH     'h16     // operator window span
`define CH_WIN_DEPTH     9        // channel window span
`define WIN_MODE_BASE    'h20
`define WIN_LEVEL_BASE   'h40
`define WIN_FNUM_LO_BASE 'hA0
`define WIN_KON_BASE     'hB0
`define WIN_FB_CNT_BASE  'hC0
`define CONN_SEL_WIDTH   6        // three 4-op pair bits per bank

`endif

// File: opl3_slot_pkg.sv
//********************
// shared types for the slot scheduler and register fetch
// register payload layouts follow the chip's bit order, msb first
//********************
package opl3_slot_pkg;

    typedef logic       bank_t;
    typedef logic [4:0] op_num_t;   // 0..17 within a bank
    typedef logic [4:0] op_addr_t;  // operator register offset
    typedef logic [3:0] ch_addr_t;  // channel index 0..8

    typedef struct packed {
        logic       am;    // tremolo
        logic       vib;   // vibrato
        logic       egt;   // sustain vs decay envelope
        logic       ksr;   // key scale rate
        logic [3:0] mult;  // frequency multiplier
    } op_mode_t;

    typedef struct packed {
        logic [1:0] ksl;   // key scale level
        logic [5:0] tl;    // total level
    } op_level_t;

    typedef logic [7:0] fnum_lo_t;

    typedef struct packed {
        logic       kon;
        logic [2:0] block;    // octave
        logic [1:0] fnum_hi;
    } kon_block_t;

    typedef struct packed {
        logic [2:0] fb;    // feedback depth
        logic       cnt;   // connection
    } fb_cnt_t;

    typedef enum logic [2:0] {
        OP_NORMAL,
        OP_BASS_DRUM,
        OP_HI_HAT,
        OP_TOM_TOM,
        OP_SNARE_DRUM,
        OP_TOP_CYMBAL
    } operator_t;

endpackage

// File: opl3_slot_sequencer.sv
//********************
// walks the 36 operator slots once per sample strobe
// bank 0 first, then bank 1; one read strobe per slot
//********************
`timescale 1ns/100ps
`include "opl3_slot_config.svh"

module opl3_slot_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   sample_clk_en,
    output opl3_slot_pkg::bank_t   bank,
    output opl3_slot_pkg::op_num_t op_num,
    output logic                   rd_en
);
    import opl3_slot_pkg::*;

    localparam int STATE_W = $clog2(`NUM_SLOTS + 1);
    localparam int CYC_W   = $clog2(`SLOT_CYCLES);

    logic [STATE_W-1:0] state;       // 0 idle, 1..36 active slot
    logic [CYC_W-1:0]   cyc_cnt;     // cycle within slot
    logic               last_cycle;

    assign last_cycle = (cyc_cnt == CYC_W'(`SLOT_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= '0;
            cyc_cnt <= '0;
        end else if (state == '0) begin
            cyc_cnt <= '0;
            if (sample_clk_en)
                state <= STATE_W'(1);
        end else if (last_cycle) begin
            cyc_cnt <= '0;
            state   <= (state == STATE_W'(`NUM_SLOTS)) ? '0 : state + 1'b1;
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;     // strobes during a pass fall through here
        end
    end

    assign bank = bank_t'(state > STATE_W'(`OPS_PER_BANK));

    always_comb begin
        if (state == '0)
            op_num = '0;
        else if (bank)
            op_num = op_num_t'(state - STATE_W'(`OPS_PER_BANK + 1));
        else
            op_num = op_num_t'(state - STATE_W'(1));
    end

    assign rd_en = (state != '0) && (cyc_cnt == '0);   // first cycle of slot

endmodule

// File: slot_address_map.sv
//********************
// maps a bank/operator pair to register offsets and channel indices
// also decodes 4-op pairing and rhythm mode into type and feedback use
//********************
`timescale 1ns/100ps
`include "opl3_slot_config.svh"

module slot_address_map (
    input  logic                      bank,
    input  opl3_slot_pkg::op_num_t    op_num,
    input  logic [`CONN_SEL_WIDTH-1:0] connection_sel,
    input  logic                      ryt,
    output opl3_slot_pkg::op_addr_t   op_addr,
    output opl3_slot_pkg::ch_addr_t   ch_addr,
    output opl3_slot_pkg::ch_addr_t   fb_ch_addr,
    output opl3_slot_pkg::operator_t  op_type,
    output logic                      use_feedback
);
    import opl3_slot_pkg::*;

    localparam int PAIRS = `CONN_SEL_WIDTH / 2;

    logic [1:0]       group;      // 0: ops 0-5, 1: ops 6-11, 2: ops 12-17
    logic [2:0]       sub;        // position inside group
    logic [1:0]       lane;       // channel inside group
    logic [PAIRS-1:0] pair_bits;
    logic             pair_bit;
    logic             rhythm;

    always_comb begin
        if (op_num < op_num_t'(6)) begin
            group = 2'd0;
            sub   = op_num[2:0];
        end else if (op_num < op_num_t'(12)) begin
            group = 2'd1;
            sub   = 3'(op_num - op_num_t'(6));
        end else begin
            group = 2'd2;
            sub   = 3'(op_num - op_num_t'(12));
        end
        lane = (sub >= 3'd3) ? 2'(sub - 3'd3) : sub[1:0];   // ops n and n+3 share
    end

    assign pair_bits = connection_sel[bank * PAIRS +: PAIRS];
    assign pair_bit  = pair_bits[lane];
    assign rhythm    = (bank == 1'b0) && ryt;

    // offsets skip 6,7 and 14,15 in each operator window
    assign op_addr    = {group, sub};
    assign fb_ch_addr = ch_addr_t'({2'b00, group} * 4'd3 + {2'b00, lane});
    // paired ops read f-number and key-on from the partner channel
    assign ch_addr    = (group == 2'd1 && pair_bit) ? ch_addr_t'(lane) : fb_ch_addr;

    always_comb begin
        use_feedback = 1'b0;
        unique case (group)
            2'd0:    use_feedback = (sub < 3'd3);
            2'd1:    use_feedback = (sub < 3'd3) && !pair_bit;
            default: begin
                if (sub == 3'd0)
                    use_feedback = 1'b1;
                else if (sub < 3'd3)
                    use_feedback = !rhythm;      // hi-hat and tom-tom slots
            end
        endcase
    end

    always_comb begin
        op_type = OP_NORMAL;
        if (rhythm && group == 2'd2) begin
            unique case (sub)
                3'd0, 3'd3: op_type = OP_BASS_DRUM;
                3'd1:       op_type = OP_HI_HAT;
                3'd2:       op_type = OP_TOM_TOM;
                3'd4:       op_type = OP_SNARE_DRUM;
                3'd5:       op_type = OP_TOP_CYMBAL;
                default:    op_type = OP_NORMAL;
            endcase
        end
    end

endmodule

// File: bank_reg_mem.sv
//********************
// one banked register window with its own write decode
// read is registered and returns the old value on a same-entry write
//********************
`timescale 1ns/100ps
`include "opl3_slot_config.svh"

module bank_reg_mem #(
    parameter type payload_t = logic [7:0],
    parameter int  BASE      = 0,
    parameter int  DEPTH     = 1
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       reg_wr_valid,
    input  opl3_slot_pkg::bank_t       reg_wr_bank,
    input  logic [7:0]                 reg_wr_address,
    input  logic [7:0]                 reg_wr_data,
    input  logic                       rd_en,
    input  opl3_slot_pkg::bank_t       rd_bank,
    input  logic [$clog2(DEPTH)-1:0]   rd_addr,
    output payload_t                   rd_data
);
    localparam int AW = $clog2(DEPTH);
    localparam int PW = $bits(payload_t);

    payload_t        mem [`NUM_BANKS][DEPTH];
    logic            wr_hit;
    logic [AW-1:0]   wr_idx;

    assign wr_hit = reg_wr_valid && int'(reg_wr_address) >= BASE
                    && int'(reg_wr_address) < BASE + DEPTH;
    assign wr_idx = AW'(reg_wr_address - 8'(BASE));

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < `NUM_BANKS; b++) begin
                for (int i = 0; i < DEPTH; i++)
                    mem[b][i] <= '0;
            end
        end else if (wr_hit) begin
            mem[reg_wr_bank][wr_idx] <= payload_t'(reg_wr_data[PW-1:0]);   // low bits only
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en)
            rd_data <= mem[rd_bank][rd_addr];
    end

endmodule

// File: slot_param_stage.sv
//********************
// registers slot identity in step with the window reads
// so each record leaves with its payloads; flags the end of a pass
//********************
`timescale 1ns/100ps
`include "opl3_slot_config.svh"

module slot_param_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     rd_en,
    input  opl3_slot_pkg::bank_t     bank,
    input  opl3_slot_pkg::op_num_t   op_num,
    input  opl3_slot_pkg::operator_t op_type,
    input  logic                     use_feedback,
    output logic                     slot_valid,
    output opl3_slot_pkg::bank_t     slot_bank,
    output opl3_slot_pkg::op_num_t   slot_op_num,
    output opl3_slot_pkg::operator_t slot_op_type,
    output logic                     slot_use_feedback,
    output logic                     slots_done
);
    import opl3_slot_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid <= 1'b0;
            slots_done <= 1'b0;
        end else begin
            slot_valid <= rd_en;
            slots_done <= slot_valid && slot_bank == bank_t'(`NUM_BANKS - 1)
                          && slot_op_num == op_num_t'(`OPS_PER_BANK - 1);   // last slot
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            slot_bank         <= bank;
            slot_op_num       <= op_num;
            slot_op_type      <= op_type;
            slot_use_feedback <= use_feedback;
        end
    end

endmodule

// File: opl3_slot_control.sv
//********************
// slot scheduler and register fetch top level
// register writes go in, one parameter record per slot comes out
//********************
`timescale 1ns/100ps
`include "opl3_slot_config.svh"

module opl3_slot_control (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       reg_wr_valid,
    input  opl3_slot_pkg::bank_t       reg_wr_bank,
    input  logic [7:0]                 reg_wr_address,
    input  logic [7:0]                 reg_wr_data,
    input  logic                       sample_clk_en,
    input  logic [`CONN_SEL_WIDTH-1:0] connection_sel,
    input  logic                       ryt,
    output logic                       slot_valid,
    output opl3_slot_pkg::bank_t       slot_bank,
    output opl3_slot_pkg::op_num_t     slot_op_num,
    output opl3_slot_pkg::operator_t   slot_op_type,
    output logic                       slot_use_feedback,
    output opl3_slot_pkg::op_mode_t    op_mode,
    output opl3_slot_pkg::op_level_t   op_level,
    output opl3_slot_pkg::fnum_lo_t    fnum_lo,
    output opl3_slot_pkg::kon_block_t  kon_block,
    output opl3_slot_pkg::fb_cnt_t     fb_cnt,
    output logic                       slots_done
);
    import opl3_slot_pkg::*;

    bank_t     bank;
    op_num_t   op_num;
    logic      rd_en;
    op_addr_t  op_addr;
    ch_addr_t  ch_addr;
    ch_addr_t  fb_ch_addr;     // own channel, even when paired
    operator_t op_type;
    logic      use_feedback;

    opl3_slot_sequencer u_seq (
        .clk, .reset, .sample_clk_en, .bank, .op_num, .rd_en
    );

    slot_address_map u_map (
        .bank, .op_num, .connection_sel, .ryt,
        .op_addr, .ch_addr, .fb_ch_addr, .op_type, .use_feedback
    );

    bank_reg_mem #(.payload_t(op_mode_t), .BASE(`WIN_MODE_BASE), .DEPTH(`OP_WIN_DEPTH))
    u_mode_mem (
        .clk, .reset, .reg_wr_valid, .reg_wr_bank, .reg_wr_address, .reg_wr_data,
        .rd_en, .rd_bank(bank), .rd_addr(op_addr), .rd_data(op_mode)
    );

    bank_reg_mem #(.payload_t(op_level_t), .BASE(`WIN_LEVEL_BASE), .DEPTH(`OP_WIN_DEPTH))
    u_level_mem (
        .clk, .reset, .reg_wr_valid, .reg_wr_bank, .reg_wr_address, .reg_wr_data,
        .rd_en, .rd_bank(bank), .rd_addr(op_addr), .rd_data(op_level)
    );

    bank_reg_mem #(.payload_t(fnum_lo_t), .BASE(`WIN_FNUM_LO_BASE), .DEPTH(`CH_WIN_DEPTH))
    u_fnum_lo_mem (
        .clk, .reset, .reg_wr_valid, .reg_wr_bank, .reg_wr_address, .reg_wr_data,
        .rd_en, .rd_bank(bank), .rd_addr(ch_addr), .rd_data(fnum_lo)
    );

    bank_reg_mem #(.payload_t(kon_block_t), .BASE(`WIN_KON_BASE), .DEPTH(`CH_WIN_DEPTH))
    u_kon_mem (
        .clk, .reset, .reg_wr_valid, .reg_wr_bank, .reg_wr_address, .reg_wr_data,
        .rd_en, .rd_bank(bank), .rd_addr(ch_addr), .rd_data(kon_block)
    );

    bank_reg_mem #(.payload_t(fb_cnt_t), .BASE(`WIN_FB_CNT_BASE), .DEPTH(`CH_WIN_DEPTH))
    u_fb_cnt_mem (
        .clk, .reset, .reg_wr_valid, .reg_wr_bank, .reg_wr_address, .reg_wr_data,
        .rd_en, .rd_bank(bank), .rd_addr(fb_ch_addr), .rd_data(fb_cnt)
    );

    slot_param_stage u_stage (
        .clk, .reset, .rd_en, .bank, .op_num, .op_type, .use_feedback,
        .slot_valid, .slot_bank, .slot_op_num, .slot_op_type, .slot_use_feedback,
        .slots_done
    );

endmodule

// File: opl3_slot_assertions.sv
//********************
// timing rules for the slot record outputs
// bound into the top level by the bind at the end of this file
//********************
`timescale 1ns/100ps
`include "opl3_slot_config.svh"

module opl3_slot_assertions (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   sample_clk_en,
    input  logic                   slot_valid,
    input  opl3_slot_pkg::bank_t   slot_bank,
    input  opl3_slot_pkg::op_num_t slot_op_num,
    input  logic                   slots_done
);
    import opl3_slot_pkg::*;

    logic       armed;        // strobe seen since the last pass ended
    logic [5:0] valid_count;  // records seen in the current pass
    logic       last_slot;
    int         failures = 0;

    assign last_slot = slot_valid && valid_count == 6'(`NUM_SLOTS - 1);   // final record of pass

    always_ff @(posedge clk) begin
        if (reset)
            armed <= 1'b0;
        else if (sample_clk_en)
            armed <= 1'b1;     // a strobe on the done cycle starts a new pass
        else if (slots_done)
            armed <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (reset)
            valid_count <= '0;
        else if (slots_done)
            valid_count <= '0;
        else if (slot_valid)
            valid_count <= valid_count + 1'b1;
    end

    valid_single: assert property (@(posedge clk) disable iff (reset)
        slot_valid |=> !slot_valid)
        else begin
            $error("slot_valid high on two consecutive cycles");
            failures++;
        end

    last_is_final_op: assert property (@(posedge clk) disable iff (reset)
        last_slot |-> (slot_bank == bank_t'(`NUM_BANKS - 1)
                       && slot_op_num == op_num_t'(`OPS_PER_BANK - 1)))
        else begin
            $error("final record of a pass is not bank 1 operator 17");
            failures++;
        end

    done_after_last: assert property (@(posedge clk) disable iff (reset)
        last_slot |=> slots_done)
        else begin
            $error("slots_done missing after bank 1 operator 17");
            failures++;
        end

    done_only_after_last: assert property (@(posedge clk) disable iff (reset)
        slots_done |-> $past(last_slot))
        else begin
            $error("slots_done without a preceding last slot");
            failures++;
        end

    valid_needs_start: assert property (@(posedge clk) disable iff (reset)
        slot_valid |-> armed)
        else begin
            $error("slot_valid while idle with no sample strobe");
            failures++;
        end

endmodule

bind opl3_slot_control opl3_slot_assertions u_assertions (
    .clk, .reset, .sample_clk_en, .slot_valid, .slot_bank, .slot_op_num, .slots_done
);

// File: slot_monitor.sv
//********************
// checker for the slot records of each pass
// matches records against entries queued by the testbench, one line per pass
//********************
`timescale 1ns/100ps
`include "opl3_slot_config.svh"

module slot_monitor (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     slot_valid,
    input  opl3_slot_pkg::bank_t     slot_bank,
    input  opl3_slot_pkg::op_num_t   slot_op_num,
    input  opl3_slot_pkg::operator_t slot_op_type,
    input  logic                     slot_use_feedback,
    input  opl3_slot_pkg::op_mode_t  op_mode,
    input  opl3_slot_pkg::op_level_t op_level,
    input  opl3_slot_pkg::fnum_lo_t  fnum_lo,
    input  opl3_slot_pkg::kon_block_t kon_block,
    input  opl3_slot_pkg::fb_cnt_t   fb_cnt,
    input  logic                     slots_done
);
    import opl3_slot_pkg::*;

    logic [43:0] exp_q[$];          // {bank, op, mode, level, fnum, kon, fb_cnt, type, use_fb}
    logic        zero_check = 1'b0;
    int          seen = 0;
    int          pass_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          error_count = 0;

    task automatic expect_slot(input logic [43:0] rec);
        exp_q.push_back(rec);
    endtask

    task automatic begin_pass(input logic zero);
        zero_check = zero;
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        pass_errors++;
        error_count++;
    endtask

    task automatic check_record();
        logic [5:0]  id;
        logic [37:0] got;
        logic        found;
        id    = {slot_bank, slot_op_num};
        got   = {op_mode, op_level, fnum_lo, kon_block, fb_cnt, slot_op_type, slot_use_feedback};
        found = 1'b0;
        if (seen >= `NUM_SLOTS)
            note_failure($sformatf("more than %0d records in one pass", `NUM_SLOTS));
        else if (id != {1'(seen >= `OPS_PER_BANK), 5'(seen % `OPS_PER_BANK)})
            note_failure($sformatf("error at %0t: record %0d is bank %0d op %0d, out of order",
                                   $time, seen, slot_bank, slot_op_num));
        if (zero_check && got[37:4] != '0)   // payload fields only
            note_failure($sformatf("error at %0t: bank %0d op %0d payloads %h, expected zero",
                                   $time, slot_bank, slot_op_num, got[37:4]));
        for (int i = 0; i < exp_q.size(); i++) begin
            if (!found && exp_q[i][43:38] == id) begin
                found = 1'b1;
                if (exp_q[i][37:0] != got)
                    note_failure($sformatf("error at %0t: bank %0d op %0d record %h, expected %h",
                                           $time, slot_bank, slot_op_num, got, exp_q[i][37:0]));
                exp_q.delete(i);
            end
        end
        seen++;
    endtask

    task automatic close_pass();
        if (seen != `NUM_SLOTS)
            note_failure($sformatf("pass had %0d records instead of %0d", seen, `NUM_SLOTS));
        while (exp_q.size() > 0) begin
            note_failure($sformatf("expected record for bank %0d op %0d never came",
                                   exp_q[0][43], exp_q[0][42:38]));
            void'(exp_q.pop_front());
        end
        tests_run++;
        if (pass_errors != 0)
            tests_failed++;
        $display("test %0d: %s, %0d records", tests_run, (pass_errors == 0) ? "ok" : "failed",
                 seen);
        seen        = 0;
        pass_errors = 0;
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (slot_valid)
                check_record();
            if (slots_done)
                close_pass();      // done comes a cycle after the last record
        end
    end

endmodule

// File: tb_opl3_slot_control.sv
//********************
// testbench for the slot scheduler top level
// replays writes and passes from the test data file, the monitor checks
//********************
`timescale 1ns/100ps
`include "opl3_slot_config.svh"

module tb_opl3_slot_control;
    import opl3_slot_pkg::*;

    localparam int DONE_TIMEOUT    = 200;
    localparam int EXTRA_STROBE_AT = 20;   // cycles into the pass

    logic                       clk;
    logic                       reset;
    logic                       reg_wr_valid;
    bank_t                      reg_wr_bank;
    logic [7:0]                 reg_wr_address;
    logic [7:0]                 reg_wr_data;
    logic                       sample_clk_en;
    logic [`CONN_SEL_WIDTH-1:0] connection_sel;
    logic                       ryt;
    logic                       slot_valid;
    bank_t                      slot_bank;
    op_num_t                    slot_op_num;
    operator_t                  slot_op_type;
    logic                       slot_use_feedback;
    op_mode_t                   op_mode;
    op_level_t                  op_level;
    fnum_lo_t                   fnum_lo;
    kon_block_t                 kon_block;
    fb_cnt_t                    fb_cnt;
    logic                       slots_done;

    string                      line;
    int                         fd;
    int                         n;
    int                         passes;
    int                         bad_lines;
    logic                       hung;
    logic                       wb;
    logic [7:0]                 wa, wd;
    logic [`CONN_SEL_WIDTH-1:0] pc;
    logic                       pr, px, pz;
    logic                       eb, eu;
    logic [4:0]                 eo;
    logic [7:0]                 em, el, ef;
    logic [5:0]                 ek;
    logic [3:0]                 efb;
    logic [2:0]                 et;

    opl3_slot_control DUT (.*);

    slot_monitor mon (.*);

    always #4 clk = ~clk;

    task automatic write_register(input logic b, input logic [7:0] a, input logic [7:0] d);
        @(posedge clk);
        #1;
        reg_wr_valid   = 1'b1;
        reg_wr_bank    = b;
        reg_wr_address = a;
        reg_wr_data    = d;
        @(posedge clk);
        #1;
        reg_wr_valid = 1'b0;
    endtask

    task automatic run_pass(input logic [`CONN_SEL_WIDTH-1:0] conn, input logic r,
                            input logic extra, input logic zero, output logic timed_out);
        int   cycles;
        logic done;
        mon.begin_pass(zero);
        @(posedge clk);
        #1;
        connection_sel = conn;
        ryt            = r;
        sample_clk_en  = 1'b1;
        cycles         = 0;
        done           = 1'b0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            sample_clk_en = extra && (cycles == EXTRA_STROBE_AT);   // ignored mid-pass
            done          = slots_done;
        end
        timed_out = !done;
        if (!done)
            $display("timeout: slots_done did not arrive within %0d cycles", DONE_TIMEOUT);
        repeat (2) @(posedge clk);   // monitor closes the pass here
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        reg_wr_valid   = 1'b0;
        reg_wr_bank    = 1'b0;
        reg_wr_address = 8'h00;
        reg_wr_data    = 8'h00;
        sample_clk_en  = 1'b0;
        connection_sel = '0;
        ryt            = 1'b0;
        passes         = 0;
        bad_lines      = 0;
        hung           = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        fd = $fopen("opl3_slot_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            $display("=== FAIL ===");
            $finish;
        end else begin
            while (!hung && $fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#")
                    continue;
                case (line.getc(0))
                    "W": begin
                        n = $sscanf(line, "W %h %h %h", wb, wa, wd);
                        if (n == 3)
                            write_register(wb, wa, wd);
                        else
                            bad_lines++;
                    end
                    "P": begin
                        n = $sscanf(line, "P %h %h %h %h", pc, pr, px, pz);
                        passes++;
                        if (n == 4)
                            run_pass(pc, pr, px, pz, hung);
                        else
                            bad_lines++;
                    end
                    "E": begin
                        n = $sscanf(line, "E %h %d %h %h %h %h %h %h %h",
                                    eb, eo, em, el, ef, ek, efb, et, eu);
                        if (n == 9)
                            mon.expect_slot({eb, eo, em, el, ef, ek, efb, et, eu});
                        else
                            bad_lines++;
                    end
                    default: bad_lines++;
                endcase
            end
            $fclose(fd);
            if (bad_lines != 0)
                $display("%0d lines of the test data file could not be read", bad_lines);
            $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                     mon.tests_run, mon.tests_failed, mon.error_count,
                     DUT.u_assertions.failures);
            if (!hung && bad_lines == 0 && mon.error_count == 0 && mon.tests_run == passes
                && DUT.u_assertions.failures == 0)
                $display("=== PASS ===");
            else
                $display("=== FAIL ===");
            $finish;
        end
    end

endmodule

// File: opl3_slot_control.f
+incdir+.
opl3_slot_pkg.sv
opl3_slot_sequencer.sv
slot_address_map.sv
bank_reg_mem.sv
slot_param_stage.sv
opl3_slot_control.sv
opl3_slot_assertions.sv
slot_monitor.sv
tb_opl3_slot_control.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the slot scheduler testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_opl3_slot_control
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" -f opl3_slot_control.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" +verilator+error+limit+100 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
exit 0

// File: opl3_slot_testdata.txt
# W bank addr data | P conn_sel ryt extra_strobe zero_payloads
# E bank op(decimal) mode level fnum_lo kon_block fb_cnt type use_fb, checked in the next pass
E 0 0 00 00 00 00 0 0 1
E 0 13 00 00 00 00 0 0 1
E 1 17 00 00 00 00 0 0 0
P 00 0 0 1
W 0 20 a1
W 0 28 37
W 0 48 c5
W 1 30 4f
W 1 55 3e
E 0 0 a1 00 00 00 0 0 1
E 0 6 37 c5 00 00 0 0 1
E 1 12 4f 00 00 00 0 0 1
E 1 17 00 3e 00 00 0 0 0
P 00 0 0 0
W 1 a0 11
W 1 b0 2d
W 1 c3 07
E 1 0 00 00 11 2d 0 0 1
E 1 6 00 00 11 2d 7 0 0
E 1 7 00 00 00 00 0 0 1
E 0 6 37 c5 00 00 0 0 1
P 08 0 0 0
E 0 12 00 00 00 00 0 1 1
E 0 13 00 00 00 00 0 2 0
E 0 14 00 00 00 00 0 3 0
E 0 15 00 00 00 00 0 1 0
E 0 16 00 00 00 00 0 4 0
E 0 17 00 00 00 00 0 5 0
E 1 12 4f 00 00 00 0 0 1
E 1 13 00 00 00 00 0 0 1
P 00 1 0 0
W 0 56 ff
W 1 a9 ff
W 1 c9 ff
W 0 1f ff
E 0 0 a1 00 00 00 0 0 1
E 1 17 00 3e 00 00 0 0 0
E 1 6 00 00 00 00 7 0 1
E 0 13 00 00 00 00 0 0 1
P 00 0 1 0
